/* list.f */
source/opn_pkg.sv
source/timer_ctrl_if.sv
source/opn_clk_div.sv
source/opn_regs.sv
source/opn_timer.sv
source/opn_timers.sv
source/opn_timing_top.sv
sim/opn_timing_checker.sv
sim/opn_timing_tb.sv

/* Makefile */
# Verilator build and run for the opn timing core testbench

VERILATOR ?= verilator
TOP       ?= opn_timing_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard source/*.sv) $(wildcard sim/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* sim/opn_timing_tb.sv */
// table-driven testbench for the opn timing core covering divider ratios, timers and flags
`timescale 1ns/1ns

module opn_timing_tb;
    import opn_pkg::*;

    localparam int k_default = 0;   // measure only, no write
    localparam int k_pres    = 1;
    localparam int k_noflag  = 2;   // timer a with flag enable clear
    localparam int k_tmr_a   = 3;
    localparam int k_tmr_b   = 4;
    localparam int k_clr     = 5;
    localparam int n_rows    = 10;

    typedef struct {
        int        kind;
        reg_addr_t addr;
        reg_data_t data;
        int        exp_op;      // operator ratio in cen cycles
        int        exp_ssg;
        int        tval;        // timer load value
        int        ticks;       // clk_en pulses measured or expected
        bit        exp_fa;
        bit        exp_fb;
        bit        exp_irq_n;
    } row_t;

    logic clk, rst_n, cen, req;
    reg_addr_t addr;
    reg_data_t wdata;
    logic ack, clk_en, clk_en_ssg, clk_en_adpcm, clk_en_adpcm3;
    logic flag_a, flag_b, irq_n;

    row_t rows [0:n_rows-1];
    logic [15:0] lfsr = 16'd70;
    int cycle_cnt = 0;
    int cycle_limit = 2000;
    int error_count = 0;
    int en_total = 0;          // all clk_en pulses seen
    int en_at_ack = 0;         // en_total just before the last ack
    int cen_since_op = 0, cen_since_ssg = 0;
    int en_since_ad = 0, en_since_ad3 = 0;
    int op_gap, ssg_gap, ad_gap, ad3_gap;
    bit cen_prev = 0;

    opn_timing_top #(.num_ch(3), .use_ssg(1)) opn_timing_top_inst (
        .clk(clk), .rst_n(rst_n), .cen(cen), .req(req), .addr(addr), .wdata(wdata),
        .ack(ack), .clk_en(clk_en), .clk_en_ssg(clk_en_ssg), .clk_en_adpcm(clk_en_adpcm),
        .clk_en_adpcm3(clk_en_adpcm3), .flag_a(flag_a), .flag_b(flag_b), .irq_n(irq_n)
    );

    always #2 clk = ~clk;

    // galois lfsr, taps for x^16+x^14+x^13+x^11+1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic check(input int actual, input int expected, input string msg);
        if (actual != expected) begin
            error_count++;
            $display("FAIL @%0t ns: %s (got %0d, expected %0d)", $time, msg, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "check mismatch");
        end
    endtask

    // one clock: sample outputs on the falling edge, then drive the next cen
    task automatic step();
        @(negedge clk);
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("*** FAILED ***");
            $fatal(1, "timeout, flags never completed");
        end
        if (cen_prev) begin
            cen_since_op++;
            cen_since_ssg++;
        end
        if (clk_en) begin
            op_gap = cen_since_op;
            cen_since_op = 0;
            en_total++;
            en_since_ad++;
            en_since_ad3++;
        end
        if (clk_en_ssg) begin
            ssg_gap = cen_since_ssg;
            cen_since_ssg = 0;
        end
        if (clk_en_adpcm) begin
            ad_gap = en_since_ad;
            en_since_ad = 0;
        end
        if (clk_en_adpcm3) begin
            ad3_gap = en_since_ad3;
            en_since_ad3 = 0;
        end
        cen = lfsr[0];       // one lfsr step per bit
        lfsr = lfsr_next(lfsr);
        cen_prev = cen;
    endtask

    // full four-phase write
    task automatic host_write(input reg_addr_t a, input reg_data_t d);
        int waited;
        addr = a;
        wdata = d;
        step();
        req = 1'b1;
        waited = 0;
        do begin
            step();
            waited++;
        end while (!ack);
        en_at_ack = en_total - int'(clk_en);
        check(waited, 2, "ack latency after req");
        req = 1'b0;
        while (ack) step();
    endtask

    // ratios measured from the first clk_en onward, first partial gaps skipped
    task automatic measure(input int exp_op, input int exp_ssg, input int pulses);
        int seen;
        int ad3_checks;
        bit ssg_first, ad_first, ad3_first;
        seen = 0;
        ad3_checks = 0;
        ssg_first = 1;
        ad_first = 1;
        ad3_first = 1;
        do step(); while (!clk_en);
        while (seen < pulses) begin
            step();
            if (clk_en) begin
                check(op_gap, exp_op, "operator enable ratio");
                seen++;
            end
            if (clk_en_ssg) begin
                if (!ssg_first) check(ssg_gap, exp_ssg, "ssg enable ratio");
                ssg_first = 0;
            end
            if (clk_en_adpcm) begin
                if (!ad_first) check(ad_gap, 4, "adpcm enable spacing");
                ad_first = 0;
            end
            if (clk_en_adpcm3) begin
                if (!ad3_first) begin
                    check(ad3_gap, 12, "adpcm3 enable spacing");
                    ad3_checks++;
                end
                ad3_first = 0;
            end
        end
        check(int'(ad3_checks > 0), 1, "no adpcm3 spacing observed");
    endtask

    task automatic run_timer(input row_t r);
        int ticks;
        if (r.kind == k_tmr_b) begin
            host_write(addr_tmr_b, reg_data_t'(r.tval));
        end else begin
            host_write(addr_tmr_a_hi, reg_data_t'(r.tval >> 2));
            host_write(addr_tmr_a_lo, reg_data_t'(r.tval & 3));
        end
        host_write(addr_tmr_ctl, 8'h00);   // stop so the next load restarts the count
        host_write(r.addr, r.data);
        if (r.kind == k_noflag) begin
            while (en_total - en_at_ack < r.ticks) begin
                step();
                check(int'(flag_a), 0, "flag_a set with enable clear");
            end
        end else begin
            while (!(r.kind == k_tmr_b ? flag_b : flag_a)) step();
            ticks = en_total - int'(clk_en) - en_at_ack;
            check(ticks, r.ticks, "clk_en pulses until flag");
        end
        step();                            // irq_n is registered
    endtask

    initial begin
        clk = 0;
        rst_n = 0;
        cen = 0;
        req = 0;
        addr = '0;
        wdata = '0;
        //         kind       addr   data  op ssg tval ticks fa fb irq_n
        rows[0] = '{k_default, 8'h00, 8'h00, 6, 4, 0,    40, 0, 0, 1};
        rows[1] = '{k_pres,    8'h2e, 8'h00, 3, 2, 0,    40, 0, 0, 1};
        rows[2] = '{k_pres,    8'h2f, 8'h00, 2, 1, 0,    40, 0, 0, 1};
        rows[3] = '{k_pres,    8'h2d, 8'h00, 6, 4, 0,    40, 0, 0, 1};
        rows[4] = '{k_pres,    8'h2f, 8'h00, 2, 1, 0,    40, 0, 0, 1};
        rows[5] = '{k_noflag,  8'h27, 8'h01, 2, 1, 1014, 20, 0, 0, 1};
        rows[6] = '{k_tmr_a,   8'h27, 8'h05, 2, 1, 984,  40, 1, 0, 0};
        rows[7] = '{k_tmr_b,   8'h27, 8'h0a, 2, 1, 253,  48, 1, 1, 0};
        rows[8] = '{k_clr,     8'h27, 8'h10, 2, 1, 0,    0,  0, 1, 0};
        rows[9] = '{k_clr,     8'h27, 8'h20, 2, 1, 0,    0,  0, 0, 1};
        for (int i = 0; i < n_rows; i++)
            cycle_limit += 8 * rows[i].ticks * rows[i].exp_op;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1;
        for (int i = 0; i < n_rows; i++) begin
            case (rows[i].kind)
                k_default: measure(rows[i].exp_op, rows[i].exp_ssg, rows[i].ticks);
                k_pres: begin
                    host_write(rows[i].addr, rows[i].data);
                    measure(rows[i].exp_op, rows[i].exp_ssg, rows[i].ticks);
                end
                k_clr: begin
                    host_write(rows[i].addr, rows[i].data);
                    step();
                    step();
                end
                default: run_timer(rows[i]);
            endcase
            check(int'(flag_a), int'(rows[i].exp_fa), "flag_a after row");
            check(int'(flag_b), int'(rows[i].exp_fb), "flag_b after row");
            check(int'(irq_n), int'(rows[i].exp_irq_n), "irq_n after row");
        end
        if (error_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "checks failed");
        end
    end
endmodule

/* sim/opn_timing_checker.sv */
// concurrent assertions on the host handshake, enable nesting and reset state of the timing core
`timescale 1ns/1ns

module opn_timing_checker (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic clk_en,
    input logic clk_en_ssg,
    input logic clk_en_adpcm,
    input logic clk_en_adpcm3,
    input logic flag_a,
    input logic flag_b
);
    // ack only answers a pending request, req seen on the edge that raised ack
    ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without req");

    // ack held until host lets go
    ack_fall_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req still high");

    adpcm_nested: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en_adpcm |-> clk_en)
        else $error("clk_en_adpcm without clk_en");

    adpcm3_nested: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en_adpcm3 |-> clk_en_adpcm)
        else $error("clk_en_adpcm3 without clk_en_adpcm");

    // everything quiet from the second reset edge on
    quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |->
        !(ack || clk_en || clk_en_ssg || clk_en_adpcm || clk_en_adpcm3 || flag_a || flag_b))
        else $error("output active during reset");
endmodule

bind opn_timing_top opn_timing_checker checker_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req           (req),
    .ack           (ack),
    .clk_en        (clk_en),
    .clk_en_ssg    (clk_en_ssg),
    .clk_en_adpcm  (clk_en_adpcm),
    .clk_en_adpcm3 (clk_en_adpcm3),
    .flag_a        (flag_a),
    .flag_b        (flag_b)
);

/* source/opn_timing_top.sv */
// opn timing core top joining the clock-enable divider, host register port and chip timers
`timescale 1ns/1ns

module opn_timing_top #(
    parameter int num_ch  = 3,   // 3 for ym2203 style, 6 fixes the /6 ratio
    parameter int use_ssg = 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  logic               req,
    input  opn_pkg::reg_addr_t addr,
    input  opn_pkg::reg_data_t wdata,
    output logic               ack,
    output logic               clk_en,
    output logic               clk_en_ssg,
    output logic               clk_en_adpcm,
    output logic               clk_en_adpcm3,
    output logic               flag_a,
    output logic               flag_b,
    output logic               irq_n
);
    import opn_pkg::*;

    div_set_t div_setting;   // prescaler code from the register block

    timer_ctrl_if tc_if ();

    opn_regs regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .div_setting (div_setting),
        .tc          (tc_if.regs)
    );

    opn_clk_div #(
        .num_ch  (num_ch),
        .use_ssg (use_ssg)
    ) clk_div_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cen           (cen),
        .div_setting   (div_setting),
        .clk_en        (clk_en),
        .clk_en_ssg    (clk_en_ssg),
        .clk_en_adpcm  (clk_en_adpcm),
        .clk_en_adpcm3 (clk_en_adpcm3)
    );

    opn_timers timers_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .clk_en (clk_en),    // timers count operator ticks
        .tc     (tc_if.timers),
        .irq_n  (irq_n)
    );

    assign flag_a = tc_if.flag_a;
    assign flag_b = tc_if.flag_b;
endmodule

/* source/opn_timers.sv */
// timers a and b, the divide-by-16 tick for timer b and the interrupt output
`timescale 1ns/1ns

module opn_timers (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clk_en,
    timer_ctrl_if.timers  tc,
    output logic          irq_n
);
    logic [3:0] sub_cnt;   // clk_en prescaler for timer b
    logic       tick_b;

    // restarts whenever load_b is low, so counting begins when it rises
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sub_cnt <= 4'd0;
        else if (!tc.load_b)
            sub_cnt <= 4'd0;
        else if (clk_en)
            sub_cnt <= sub_cnt + 4'd1;
    end

    assign tick_b = clk_en && tc.load_b && (sub_cnt == 4'hf);   // every 16th clk_en

    opn_timer #(.cnt_w(10)) timer_a_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (clk_en),     // timer a runs at the operator rate
        .load     (tc.load_a),
        .value    (tc.value_a),
        .flag_en  (tc.en_a),
        .flag_clr (tc.clr_a),
        .flag     (tc.flag_a)
    );

    opn_timer #(.cnt_w(8)) timer_b_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick_b),
        .load     (tc.load_b),
        .value    (tc.value_b),
        .flag_en  (tc.en_b),
        .flag_clr (tc.clr_b),
        .flag     (tc.flag_b)
    );

    // active-low interrupt while either flag stands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            irq_n <= 1'b1;
        else
            irq_n <= !(tc.flag_a || tc.flag_b);
    end
endmodule

/* source/opn_timer.sv */
// loadable up-counting timer with reload on wrap and a sticky overflow flag
`timescale 1ns/1ns

module opn_timer #(
    parameter int cnt_w = 10   // 10 for timer a, 8 for timer b
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,
    input  logic             load,
    input  logic [cnt_w-1:0] value,
    input  logic             flag_en,
    input  logic             flag_clr,
    output logic             flag
);
    logic [cnt_w-1:0] cnt;
    logic             wrap;

    // last count before overflow, only while running
    assign wrap = load && tick && (cnt == {cnt_w{1'b1}});

    // counter follows value while stopped
    // so the first tick after load rises counts from value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!load) begin
            cnt <= value;
        end else if (tick) begin
            if (wrap)
                cnt <= value;          // reload on overflow
            else
                cnt <= cnt + 1'b1;
        end
    end

    // flag set one cycle after the wrapping tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag <= 1'b0;
        end else if (flag_clr) begin
            flag <= 1'b0;              // clear wins over a same-cycle set
        end else if (wrap && flag_en) begin
            flag <= 1'b1;
        end
    end
endmodule

/* source/opn_regs.sv */
// host register block with four-phase write handshake and prescaler and timer register decode
`timescale 1ns/1ns

module opn_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  opn_pkg::reg_addr_t addr,
    input  opn_pkg::reg_data_t wdata,
    output logic               ack,
    output opn_pkg::div_set_t  div_setting,
    timer_ctrl_if.regs         tc
);
    import opn_pkg::*;

    host_state_t state;
    reg_addr_t   addr_q;      // sampled in idle
    reg_data_t   data_q;
    logic        wr_stb;      // one cycle per accepted request
    logic [7:0]  tmr_a_hi;    // timer a bits 9..2
    logic [1:0]  tmr_a_lo;    // timer a bits 1..0
    timer_b_t    tmr_b;

    // handshake fsm
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req)
                        state <= st_write;    // addr and data captured this edge
                end
                st_write: begin
                    ack   <= 1'b1;            // rises together with the register update
                    state <= st_wait_release;
                end
                st_wait_release: begin
                    if (!req) begin           // host may hold req as long as it likes
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request capture
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            addr_q <= addr;
            data_q <= wdata;
        end
    end

    assign wr_stb = (state == st_write);

    // register decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_setting <= div_6;
            tmr_a_hi    <= 8'd0;
            tmr_a_lo    <= 2'd0;
            tmr_b       <= '0;
            tc.load_a   <= 1'b0;
            tc.load_b   <= 1'b0;
            tc.en_a     <= 1'b0;
            tc.en_b     <= 1'b0;
            tc.clr_a    <= 1'b0;
            tc.clr_b    <= 1'b0;
        end else begin
            tc.clr_a <= 1'b0;   // clears last one cycle
            tc.clr_b <= 1'b0;
            if (wr_stb) begin
                case (addr_q)
                    addr_tmr_a_hi: tmr_a_hi <= data_q;
                    addr_tmr_a_lo: tmr_a_lo <= data_q[1:0];
                    addr_tmr_b:    tmr_b    <= data_q;
                    addr_tmr_ctl: begin
                        tc.load_a <= data_q[ctl_load_a];
                        tc.load_b <= data_q[ctl_load_b];
                        tc.en_a   <= data_q[ctl_en_a];
                        tc.en_b   <= data_q[ctl_en_b];
                        tc.clr_a  <= data_q[ctl_clr_a];
                        tc.clr_b  <= data_q[ctl_clr_b];
                    end
                    addr_pres6: div_setting <= div_6;   // data ignored on prescaler writes
                    addr_pres3: div_setting <= div_3;
                    addr_pres2: div_setting <= div_2;
                    default: ;
                endcase
            end
        end
    end

    assign tc.value_a = {tmr_a_hi, tmr_a_lo};
    assign tc.value_b = tmr_b;
endmodule

/* source/opn_clk_div.sv */
// clock-enable divider making the operator, ssg and adpcm enables from the host cen
`timescale 1ns/1ns

module opn_clk_div #(
    parameter int num_ch  = 6,   // 3 or 6, six channels fixes the ratio at /6
    parameter int use_ssg = 0    // zero keeps clk_en_ssg low
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  opn_pkg::div_set_t div_setting,
    output logic              clk_en,
    output logic              clk_en_ssg,
    output logic              clk_en_adpcm,
    output logic              clk_en_adpcm3
);
    import opn_pkg::*;

    logic [2:0] opn_pres;     // operator ratio minus one
    logic [1:0] ssg_pres;     // ssg ratio minus one
    logic [2:0] opn_cnt;
    logic [1:0] ssg_cnt;
    logic [1:0] adpcm_cnt;    // counts operator enables mod 4
    logic [1:0] adpcm3_cnt;   // counts adpcm enables mod 3
    div_set_t   div_q;        // last setting seen
    logic       set_chg;
    logic       opn_zero;
    logic       adpcm_zero;
    logic       adpcm3_zero;

    // preset decode
    always_comb begin
        if (num_ch == 6) begin
            opn_pres = 3'd5;
            ssg_pres = 2'd3;
        end else begin
            case (div_setting)
                div_6: begin
                    opn_pres = 3'd5;
                    ssg_pres = 2'd3;     // ssg every 4 cen
                end
                div_3: begin
                    opn_pres = 3'd2;
                    ssg_pres = 2'd1;
                end
                default: begin           // 2'b0x is /2
                    opn_pres = 3'd1;
                    ssg_pres = 2'd0;
                end
            endcase
        end
    end

    assign set_chg     = (num_ch != 6) && (div_setting != div_q);
    assign opn_zero    = cen && (opn_cnt == 3'd0);
    assign adpcm_zero  = opn_zero && (adpcm_cnt == 2'd0);    // every 4th operator enable
    assign adpcm3_zero = adpcm_zero && (adpcm3_cnt == 2'd0); // every 3rd adpcm enable

    // counters advance on cen, restart on a setting change
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opn_cnt    <= 3'd0;
            ssg_cnt    <= 2'd0;
            adpcm_cnt  <= 2'd0;
            adpcm3_cnt <= 2'd0;
            div_q      <= div_6;
        end else if (set_chg) begin
            opn_cnt    <= 3'd0;   // next cen gives the first enable at the new ratio
            ssg_cnt    <= 2'd0;
            adpcm_cnt  <= 2'd0;
            adpcm3_cnt <= 2'd0;
            div_q      <= div_setting;
        end else if (cen) begin
            opn_cnt <= (opn_cnt == opn_pres) ? 3'd0 : opn_cnt + 3'd1;
            ssg_cnt <= (ssg_cnt == ssg_pres) ? 2'd0 : ssg_cnt + 2'd1;
            if (opn_zero) begin
                adpcm_cnt <= adpcm_cnt + 2'd1;     // wraps at 4 by width
                if (adpcm_cnt == 2'd0)
                    adpcm3_cnt <= (adpcm3_cnt == 2'd2) ? 2'd0 : adpcm3_cnt + 2'd1;
            end
        end
    end

    // registered enables, one cycle after the zero-count cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_en        <= 1'b0;
            clk_en_ssg    <= 1'b0;
            clk_en_adpcm  <= 1'b0;
            clk_en_adpcm3 <= 1'b0;
        end else begin
            clk_en        <= opn_zero && !set_chg;   // no stale pulse across a ratio change
            clk_en_ssg    <= (use_ssg != 0) && cen && (ssg_cnt == 2'd0) && !set_chg;
            clk_en_adpcm  <= adpcm_zero && !set_chg;
            clk_en_adpcm3 <= adpcm3_zero && !set_chg;
        end
    end
endmodule

/* source/timer_ctrl_if.sv */
// timer control interface carrying load values and control bits to the timers and flags back
`timescale 1ns/1ns

interface timer_ctrl_if;
    import opn_pkg::*;

    timer_a_t value_a;   // timer a load value
    timer_b_t value_b;   // timer b load value
    logic     load_a;    // run levels
    logic     load_b;
    logic     en_a;      // flag enables
    logic     en_b;
    logic     clr_a;     // single-cycle clears
    logic     clr_b;
    logic     flag_a;    // overflow flags from the timers
    logic     flag_b;

    modport regs (
        output value_a, value_b, load_a, load_b, en_a, en_b, clr_a, clr_b,
        input  flag_a, flag_b
    );

    modport timers (
        input  value_a, value_b, load_a, load_b, en_a, en_b, clr_a, clr_b,
        output flag_a, flag_b
    );
endinterface

/* source/opn_pkg.sv */
// opn timing package with shared widths, register map, handshake states and prescaler codes
package opn_pkg;

    typedef logic [7:0] reg_addr_t;   // host register address
    typedef logic [7:0] reg_data_t;   // host write data
    typedef logic [1:0] div_set_t;    // prescaler code
    typedef logic [9:0] timer_a_t;    // timer a load value
    typedef logic [7:0] timer_b_t;    // timer b load value

    // host write handshake
    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_wait_release
    } host_state_t;

    // register map
    localparam reg_addr_t addr_tmr_a_hi = 8'h24;  // timer a bits 9..2
    localparam reg_addr_t addr_tmr_a_lo = 8'h25;  // timer a bits 1..0 in data[1:0]
    localparam reg_addr_t addr_tmr_b    = 8'h26;
    localparam reg_addr_t addr_tmr_ctl  = 8'h27;
    localparam reg_addr_t addr_pres6    = 8'h2d;
    localparam reg_addr_t addr_pres3    = 8'h2e;
    localparam reg_addr_t addr_pres2    = 8'h2f;

    // bit positions in 0x27
    localparam int ctl_load_a = 0;    // level, timer a runs while set
    localparam int ctl_load_b = 1;
    localparam int ctl_en_a   = 2;    // flag enables
    localparam int ctl_en_b   = 3;
    localparam int ctl_clr_a  = 4;    // one-shot clears, never stored
    localparam int ctl_clr_b  = 5;

    // prescaler codes
    localparam div_set_t div_6 = 2'b10;  // reset value
    localparam div_set_t div_3 = 2'b11;
    localparam div_set_t div_2 = 2'b00;

endpackage
